// File: hdl/jobFifo.sv
`timescale 1ns/10ps
`include "radixMul_defines.svh"

module jobFifo (
	input  logic                     Clock,
	input  logic                     reset,
	output logic [`LEVEL_WIDTH-1:0]  level,
	mulJobIf.sink                    push,
	mulJobIf.source                  pop
);

	localparam int PtrWidth = $clog2(`FIFO_DEPTH);

	radixMulPkg::operandPair operandMem [`FIFO_DEPTH];
	radixMulPkg::jobTag tagMem [`FIFO_DEPTH];

	logic [PtrWidth-1:0] wrPtr;
	logic [PtrWidth-1:0] rdPtr;
	logic [`LEVEL_WIDTH-1:0] count;
	logic full;
	logic doPush;
	logic doPop;

	assign full = (count == `FIFO_DEPTH);

	// a full FIFO still takes a job when one leaves in the same cycle
	assign push.ready = !full || pop.ready;
	assign doPush = push.valid && push.ready;

	assign pop.valid = (count != '0);
	assign pop.operands = operandMem[rdPtr];
	assign pop.tag = tagMem[rdPtr];
	assign doPop = pop.valid && pop.ready;

	assign level = count;

	// ------------------------------------------------------------
	// pointers and occupancy
	// ------------------------------------------------------------
	always_ff @(posedge Clock) begin
		if (reset) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (doPush)
				wrPtr <= wrPtr + 1'b1;
			if (doPop)
				rdPtr <= rdPtr + 1'b1;
			case ({doPush, doPop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;   // none, or push and pop together
			endcase
		end
	end

	// storage
	always_ff @(posedge Clock) begin
		if (doPush) begin
			operandMem[wrPtr] <= push.operands;
			tagMem[wrPtr] <= push.tag;
		end
	end

endmodule

// File: hdl/mulJobIf.sv
`timescale 1ns/10ps

// one multiply job with valid/ready handshake
interface mulJobIf;

	logic valid;
	logic ready;
	radixMulPkg::operandPair operands;
	radixMulPkg::jobTag tag;

	modport source (
		output valid,
		output operands,
		output tag,
		input  ready
	);

	modport sink (
		input  valid,
		input  operands,
		input  tag,
		output ready
	);

endinterface

// File: hdl/radix4Multiplier.sv
`timescale 1ns/10ps
`include "radixMul_defines.svh"

module radix4Multiplier (
	input  logic                       Clock,
	input  logic                       reset,
	input  logic                       productReady,
	output logic [`PRODUCT_WIDTH-1:0]  product,
	output radixMulPkg::jobTag         productTag,
	output logic                       productValid,
	output logic                       busy,
	mulJobIf.sink                      job
);

	localparam int StepCount = `MUL_WIDTH / 2;        // one radix-4 digit per step
	localparam int StepWidth = $clog2(StepCount + 1);
	localparam logic [StepWidth-1:0] LastStep = StepWidth'(StepCount);

	typedef enum logic [1:0] {
		stateIdle,
		stateRun,
		stateHold
	} mulState;

	mulState state;
	logic [StepWidth-1:0] step;
	logic [`PRODUCT_WIDTH-1:0] multiplicand;   // shifted left by two each step
	logic [`MUL_WIDTH-1:0] multiplier;         // shifted right by two each step
	logic [`PRODUCT_WIDTH-1:0] acc;
	logic [`PRODUCT_WIDTH-1:0] partial;

	assign job.ready = (state == stateIdle);
	assign busy = (state != stateIdle);
	assign productValid = (state == stateHold);

	// 0, 1, 2 or 3 times the multiplicand for the lowest digit
	always_comb begin
		case (multiplier[1:0])
			2'd0:    partial = '0;
			2'd1:    partial = multiplicand;
			2'd2:    partial = multiplicand << 1;
			default: partial = (multiplicand << 1) + multiplicand;
		endcase
	end

	// ------------------------------------------------------------
	// control
	// ------------------------------------------------------------
	always_ff @(posedge Clock) begin
		if (reset) begin
			state <= stateIdle;
			step <= '0;
		end else begin
			case (state)
				stateIdle: begin
					step <= '0;
					if (job.valid)
						state <= stateRun;
				end
				stateRun: begin
					if (step == LastStep)
						state <= stateHold;   // result written this edge
					else
						step <= step + 1'b1;
				end
				stateHold: begin
					if (productReady)
						state <= stateIdle;
				end
				default: state <= stateIdle;
			endcase
		end
	end

	// ------------------------------------------------------------
	// datapath
	// ------------------------------------------------------------
	always_ff @(posedge Clock) begin
		if (job.valid && job.ready) begin
			multiplicand <= {{`MUL_WIDTH{1'b0}}, job.operands.multiplicand};
			multiplier <= job.operands.multiplier;
			acc <= '0;
			productTag <= job.tag;   // held until the result is taken
		end else if (state == stateRun) begin
			if (step == LastStep) begin
				product <= acc;
			end else begin
				acc <= acc + partial;
				multiplicand <= multiplicand << 2;
				multiplier <= multiplier >> 2;
			end
		end
	end

endmodule

// File: hdl/radixMulPkg.sv
`include "radixMul_defines.svh"

package radixMulPkg;

	typedef logic [`TAG_WIDTH-1:0] jobTag;

	// one multiply job, multiplicand in the upper half
	typedef struct packed {
		logic [`MUL_WIDTH-1:0] multiplicand;
		logic [`MUL_WIDTH-1:0] multiplier;
	} operandPair;

	typedef struct packed {
		logic [7:0]  level;     // jobs waiting in the FIFO
		jobTag       nextTag;   // tag the next write will get
		logic        busy;      // multiplier running or holding
		logic [14:0] reserved;  // reads as zero
	} statusWord;

	// bus data word, decoded by address
	typedef union packed {
		operandPair operands;
		statusWord  status;
	} busWord;

endpackage

// File: hdl/radixMulTop.sv
`timescale 1ns/10ps
`include "radixMul_defines.svh"

module radixMulTop (
	input  logic                       Clock,
	input  logic                       reset,

	// wishbone classic slave
	input  logic                       cyc,
	input  logic                       stb,
	input  logic                       we,
	input  logic [`ADDR_WIDTH-1:0]     adr,
	input  logic [31:0]                datIn,
	output logic [31:0]                datOut,
	output logic                       ack,

	// result port
	output logic [`PRODUCT_WIDTH-1:0]  product,
	output radixMulPkg::jobTag         productTag,
	output logic                       productValid,
	input  logic                       productReady
);

	logic [`LEVEL_WIDTH-1:0] fifoLevel;
	logic mulBusy;

	mulJobIf writerToFifo ();
	mulJobIf fifoToMul ();

	// ------------------------------------------------------------
	// producer, buffer, consumer
	// ------------------------------------------------------------
	wbJobWriter u_wbJobWriter (
		.Clock     (Clock),
		.reset     (reset),
		.cyc       (cyc),
		.stb       (stb),
		.we        (we),
		.adr       (adr),
		.datIn     (datIn),
		.datOut    (datOut),
		.ack       (ack),
		.fifoLevel (fifoLevel),
		.mulBusy   (mulBusy),
		.job       (writerToFifo.source)
	);

	jobFifo u_jobFifo (
		.Clock (Clock),
		.reset (reset),
		.level (fifoLevel),
		.push  (writerToFifo.sink),
		.pop   (fifoToMul.source)
	);

	radix4Multiplier u_radix4Multiplier (
		.Clock        (Clock),
		.reset        (reset),
		.productReady (productReady),
		.product      (product),
		.productTag   (productTag),
		.productValid (productValid),
		.busy         (mulBusy),
		.job          (fifoToMul.sink)
	);

endmodule

// File: hdl/radixMul_defines.svh
`ifndef RADIXMUL_DEFINES_SVH
`define RADIXMUL_DEFINES_SVH

// operand and product widths
`define MUL_WIDTH 16
`define PRODUCT_WIDTH (2 * `MUL_WIDTH)
`define TAG_WIDTH 8

// job FIFO, power of two entries only
`define FIFO_DEPTH 4
`define LEVEL_WIDTH ($clog2(`FIFO_DEPTH) + 1)

`define ADDR_WIDTH 2
`define ADDR_OPERAND 2'd0   // operand pair write
`define ADDR_STATUS 2'd1    // status read

`endif

// File: hdl/wbJobWriter.sv
`timescale 1ns/10ps
`include "radixMul_defines.svh"

module wbJobWriter (
	input  logic                     Clock,
	input  logic                     reset,
	input  logic                     cyc,
	input  logic                     stb,
	input  logic                     we,
	input  logic [`ADDR_WIDTH-1:0]   adr,
	input  logic [31:0]              datIn,
	output logic [31:0]              datOut,
	output logic                     ack,
	input  logic [`LEVEL_WIDTH-1:0]  fifoLevel,
	input  logic                     mulBusy,
	mulJobIf.source                  job
);

	logic cycle;
	logic operandWrite;
	radixMulPkg::jobTag tagCount;
	radixMulPkg::busWord wordIn;
	radixMulPkg::busWord statusOut;

	assign cycle = cyc && stb;
	assign operandWrite = we && (adr == `ADDR_OPERAND);

	// ------------------------------------------------------------
	// job side
	// ------------------------------------------------------------
	assign wordIn = datIn;

	// offered straight from the bus so the FIFO can take it this cycle
	assign job.valid = cycle && operandWrite && !ack;
	assign job.operands = wordIn.operands;
	assign job.tag = tagCount;

	always_ff @(posedge Clock) begin
		if (reset)
			tagCount <= '0;
		else if (job.valid && job.ready)
			tagCount <= tagCount + 1'b1;   // wraps at 256
	end

	// ------------------------------------------------------------
	// bus acknowledge
	// ------------------------------------------------------------
	always_ff @(posedge Clock) begin
		if (reset) begin
			ack <= 1'b0;
		end else begin
			ack <= 1'b0;
			if (cycle && !ack) begin
				if (operandWrite)
					ack <= job.ready;   // stall while FIFO is full
				else
					ack <= 1'b1;        // status read or ignored write
			end
		end
	end

	// status record packed into the bus word
	always_comb begin
		statusOut = '0;
		statusOut.status.level = 8'(fifoLevel);
		statusOut.status.nextTag = tagCount;
		statusOut.status.busy = mulBusy;
	end

	assign datOut = (!we && adr == `ADDR_STATUS) ? statusOut : '0;

endmodule

// File: radixMulTop.f
+incdir+hdl
hdl/radixMulPkg.sv
hdl/mulJobIf.sv
hdl/wbJobWriter.sv
hdl/jobFifo.sv
hdl/radix4Multiplier.sv
hdl/radixMulTop.sv
sim/tbRadixMul.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tbRadixMul -f radixMulTop.f -o VtbRadixMul
./obj_dir/VtbRadixMul > sim.log 2>&1 || true
cat sim.log

if grep -q "All tests passed" sim.log; then
	exit 0
fi
echo "simulation did not pass, see sim.log"
exit 1

// File: sim/tbRadixMul.sv
`timescale 1ns/10ps
`include "radixMul_defines.svh"

module tbRadixMul;

	localparam int ClockPeriod = 4;
	localparam int TotalJobs = 29 + 200 + 1 + 6 + 100;
	localparam int ReadyLow = 0;
	localparam int ReadyHigh = 1;
	localparam int ReadyRandom = 2;

	logic Clock = 1'b0;
	logic reset;
	logic cyc;
	logic stb;
	logic we;
	logic [`ADDR_WIDTH-1:0] adr;
	logic [31:0] datIn;
	logic [31:0] datOut;
	logic ack;
	logic [`PRODUCT_WIDTH-1:0] product;
	radixMulPkg::jobTag productTag;
	logic productValid;
	logic productReady = 1'b0;

	logic [31:0] lfsrState = 32'heed064b6;
	int readyMode = ReadyHigh;
	radixMulPkg::jobTag nextTag;
	logic [39:0] expected [$];   // {tag, product} per job in flight
	logic heldValid;
	logic [31:0] heldProduct;
	radixMulPkg::jobTag heldTag;

	radixMulTop u_radixMulTop (.*);

	always #(ClockPeriod / 2) Clock = ~Clock;

	// ------------------------------------------------------------
	// helpers
	// ------------------------------------------------------------
	// galois LFSR with taps for x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsrStep(input logic [31:0] state);
		return state[0] ? ((state >> 1) ^ 32'h80200003) : (state >> 1);
	endfunction

	task automatic takeBits(input int count, output logic [31:0] value);
		value = '0;
		for (int i = 0; i < count; i++) begin
			lfsrState = lfsrStep(lfsrState);
			value = {value[30:0], lfsrState[0]};   // one step per bit
		end
	endtask

	function automatic logic [31:0] mulReference(input logic [15:0] a, input logic [15:0] b);
		return {16'h0, a} * {16'h0, b};
	endfunction

	task automatic abortRun(input string reason);
		$display("%s", reason);
		$display("Some tests failed");
		$fatal(1);
	endtask

	task automatic checkValue(input string name, input logic [31:0] expectedValue,
			input logic [31:0] got);
		if (got !== expectedValue) begin
			$display("[FAIL] %s expected %h got %h", name, expectedValue, got);
			abortRun("value mismatch");
		end
	endtask

	// one wishbone classic cycle that ends after the ack
	task automatic busCycle(input logic write, input logic [`ADDR_WIDTH-1:0] addr,
			input logic [31:0] wdata, output logic [31:0] rdata);
		cyc = 1'b1;
		stb = 1'b1;
		we = write;
		adr = addr;
		datIn = wdata;
		do
			@(posedge Clock);
		while (!ack);
		rdata = datOut;
		#0.5;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
	endtask

	task automatic sendJob(input logic [15:0] a, input logic [15:0] b);
		radixMulPkg::busWord word;
		logic [31:0] readBack;
		word.operands.multiplicand = a;
		word.operands.multiplier = b;
		expected.push_back({nextTag, mulReference(a, b)});
		nextTag++;
		busCycle(1'b1, `ADDR_OPERAND, word, readBack);
	endtask

	task automatic applyReset();
		reset = 1'b1;
		repeat (2) @(posedge Clock);
		#0.5;
		reset = 1'b0;
	endtask

	task automatic waitIdle();
		do begin
			@(posedge Clock);
			#0.5;
		end while (expected.size() != 0);
	endtask

	// ------------------------------------------------------------
	// result side
	// ------------------------------------------------------------
	always begin
		logic [31:0] bits;
		@(posedge Clock);
		bits = 32'(readyMode == ReadyHigh);
		if (readyMode == ReadyRandom)
			takeBits(1, bits);
		#0.5;
		productReady = bits[0];
	end

	always @(posedge Clock) begin
		logic [39:0] entry;
		if (reset) begin
			heldValid <= 1'b0;
		end else begin
			if (heldValid) begin   // result not taken last cycle
				checkValue("productValid", 32'h1, 32'(productValid));
				checkValue("product", heldProduct, product);
				checkValue("productTag", 32'(heldTag), 32'(productTag));
			end
			if (productValid && productReady) begin
				if (expected.size() == 0)
					abortRun("a result arrived with no job outstanding");
				entry = expected.pop_front();
				checkValue("product", entry[31:0], product);
				checkValue("productTag", 32'(entry[39:32]), 32'(productTag));
			end
			heldValid <= productValid && !productReady;
			heldProduct <= product;
			heldTag <= productTag;
		end
	end

	initial begin
		#(ClockPeriod * (TotalJobs * 40 + 200));
		abortRun("timeout, the results did not all arrive in time");
	end

	// ------------------------------------------------------------
	// test sequence
	// ------------------------------------------------------------
	initial begin
		logic [31:0] bits;
		logic [31:0] readData;
		radixMulPkg::busWord word;
		int edges;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		adr = '0;
		datIn = '0;
		nextTag = '0;
		applyReset();

		// empty after reset
		busCycle(1'b0, `ADDR_STATUS, '0, readData);
		checkValue("status", 32'h0, readData);

		sendJob(16'h0000, 16'h1234);
		sendJob(16'hBEEF, 16'h0000);
		sendJob(16'hFFFF, 16'hFFFF);
		sendJob(16'h0001, 16'hA5C3);
		sendJob(16'h7E21, 16'h0001);
		for (int d = 1; d < 4; d++)
			for (int p = 0; p < 8; p++)
				sendJob(16'hFFFF, 16'(d << (2 * p)));   // one digit in each position
		waitIdle();

		applyReset();
		nextTag = '0;
		repeat (200) begin
			takeBits(32, bits);
			sendJob(bits[31:16], bits[15:0]);
		end
		waitIdle();

		// ack edge is the edge the multiplier takes the job
		sendJob(16'h1357, 16'h9BDF);
		edges = 0;
		do begin
			@(posedge Clock);
			edges++;
		end while (!productValid);
		#0.5;
		checkValue("latency", 32'd9, edges - 1);   // seen one sample after the rise
		waitIdle();

		readyMode = ReadyLow;
		repeat (5) begin
			takeBits(32, bits);
			sendJob(bits[31:16], bits[15:0]);
		end
		do
			@(posedge Clock);
		while (!productValid);
		#0.5;
		takeBits(32, bits);
		word.operands.multiplicand = bits[31:16];
		word.operands.multiplier = bits[15:0];
		cyc = 1'b1;
		stb = 1'b1;
		we = 1'b1;
		adr = `ADDR_OPERAND;
		datIn = word;
		repeat (20) begin   // FIFO full and a result held
			@(posedge Clock);
			checkValue("ack", 32'h0, 32'(ack));
		end
		#0.5;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		busCycle(1'b0, `ADDR_STATUS, '0, readData);
		word = '0;
		word.status.level = 8'(`FIFO_DEPTH);
		word.status.nextTag = nextTag;
		word.status.busy = 1'b1;
		checkValue("status", word, readData);

		// operand address reads zero while the status is not
		busCycle(1'b0, `ADDR_OPERAND, '0, readData);
		checkValue("operand read", 32'h0, readData);

		readyMode = ReadyHigh;
		sendJob(bits[31:16], bits[15:0]);
		waitIdle();

		readyMode = ReadyRandom;
		repeat (100) begin
			takeBits(32, bits);
			sendJob(bits[31:16], bits[15:0]);
		end
		waitIdle();

		$display("All tests passed");
		$finish;
	end

endmodule
